//--- all.f
musicBoxPkg.sv
keySmoother.sv
toneGenerator.sv
sampleFifo.sv
dacSpiSerializer.sv
musicBox.sv
musicBox_properties.sv
tb_musicBox.sv

//--- dacSpiSerializer.sv
/*
	DAC SPI serializer
	Takes one sample at a time and shifts it out MSB first as a 16-bit
	frame with four zero control bits, then holds SYNC high for the gap
*/
module dacSpiSerializer (
	input  logic                   clock_50Mhz,
	input  logic                   reset,
	input  logic                   dacValid,
	input  musicBoxPkg::dacSampleT dacSample,
	output logic                   dacCredit,
	output logic                   spiSclk,
	output logic                   spiSyncN,
	output logic                   spiDin
);
	import musicBoxPkg::*;

	serializerStateT state;
	sclkCountT       divCount;    // Cycles into the SCLK half period
	bitCountT        bitCount;
	gapCountT        gapCount;
	frameT           shiftReg;
	dacSampleT       holdSample;  // One sample waiting for the shifter
	logic            holdValid;

	logic            halfDone;
	logic            risingEdge;
	logic            frameDone;
	logic            gapDone;
	logic            take;

	assign halfDone   = (state == SerShift) && (divCount == sclkCountT'(SCLK_HALF - 1));
	assign frameDone  = halfDone && !spiSclk && (bitCount == bitCountT'(FRAME_BITS - 1));
	assign risingEdge = halfDone && !spiSclk && !frameDone;
	assign gapDone    = (state == SerGap) && (gapCount == gapCountT'(GAP_CYCLES - 1));
	assign take       = holdValid && ((state == SerIdle) || gapDone);
	assign dacCredit  = take;  // Holding slot free again

	always_ff @(posedge clock_50Mhz) begin
		if (reset)
			holdValid <= 1'b0;
		else
			holdValid <= dacValid || (holdValid && !take);
	end

	always_ff @(posedge clock_50Mhz) begin
		if (dacValid)
			holdSample <= dacSample;
	end

	// ------------------------------------------------------------------
	// Frame FSM
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			state    <= SerIdle;
			divCount <= '0;
			bitCount <= '0;
			gapCount <= '0;
			spiSclk  <= 1'b0;
			spiSyncN <= 1'b1;
			spiDin   <= 1'b0;
		end else if (take) begin
			state    <= SerShift;
			divCount <= '0;
			bitCount <= '0;
			spiSyncN <= 1'b0;
			spiSclk  <= 1'b1;   // First rising edge with SYNC
			spiDin   <= 1'b0;   // Top control bit
		end else begin
			if (state == SerShift)
				divCount <= halfDone ? '0 : divCount + 1'b1;
			if (halfDone && spiSclk)
				spiSclk <= 1'b0;  // DAC latches on the fall
			if (risingEdge) begin
				spiSclk  <= 1'b1;
				spiDin   <= shiftReg[FRAME_BITS-2];  // Data moves on the rise
				bitCount <= bitCount + 1'b1;
			end
			if (frameDone) begin
				state    <= SerGap;
				spiSyncN <= 1'b1;
				spiDin   <= 1'b0;
				gapCount <= '0;
			end
			if (state == SerGap) begin
				if (gapDone)
					state <= SerIdle;  // Nothing waiting
				else
					gapCount <= gapCount + 1'b1;
			end
		end
	end

	always_ff @(posedge clock_50Mhz) begin
		if (take)
			shiftReg <= frameT'(holdSample);  // Zero extend gives the control bits
		else if (risingEdge)
			shiftReg <= shiftReg << 1;
	end

endmodule

//--- keySmoother.sv
/*
	Music key smoother
	Synchronizes the six active-low keys and debounces them as one mask
*/
module keySmoother (
	input  logic                 clock_50Mhz,
	input  logic                 reset,
	input  musicBoxPkg::keyMaskT musicKeys,    // Active low from the pins
	output musicBoxPkg::keyMaskT pressedKeys   // Active high, stable
);
	import musicBoxPkg::*;

	keyMaskT       syncMeta;        // First synchronizer stage
	keyMaskT       syncKeys;        // Second stage
	keyMaskT       rawPressed;
	keyMaskT       candidateKeys;   // Mask being timed
	debounceCountT stableCount;     // Shared by all six keys

	assign rawPressed = ~syncKeys;  // Pressed reads as 1 from here on

	// ------------------------------------------------------------------
	// Two-flop synchronizer
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			syncMeta <= '1;  // All released
			syncKeys <= '1;
		end else begin
			syncMeta <= musicKeys;
			syncKeys <= syncMeta;
		end
	end

	// ------------------------------------------------------------------
	// Stability counter
	// ------------------------------------------------------------------
	// Any bit moving restarts the wait for the whole mask
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			candidateKeys <= '0;
			stableCount   <= '0;
			pressedKeys   <= '0;
		end else if (rawPressed != candidateKeys) begin
			candidateKeys <= rawPressed;
			stableCount   <= '0;
		end else if (stableCount == debounceCountT'(DEBOUNCE_CYCLES - 1)) begin
			pressedKeys <= candidateKeys;  // Held long enough
		end else begin
			stableCount <= stableCount + 1'b1;
		end
	end

endmodule

//--- musicBox.sv
/*
	Music box live-play top
	Keys to debouncer, tone generator, sample FIFO and DAC SPI serializer
*/
module musicBox (
	input  logic                 clock_50Mhz,
	input  logic                 reset,
	input  musicBoxPkg::keyMaskT musicKeys,   // Active low
	output logic                 spiSclk,
	output logic                 spiSyncN,
	output logic                 spiDin
);
	import musicBoxPkg::*;

	keyMaskT   pressedKeys;
	logic      sampleValid;
	dacSampleT sample;
	logic      sampleCredit;   // FIFO back to producer
	logic      dacValid;
	dacSampleT dacSample;
	logic      dacCredit;      // Serializer back to FIFO

	// ------------------------------------------------------------------
	// Producer, buffer and consumer chain
	// ------------------------------------------------------------------
	keySmoother smoother (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.musicKeys(musicKeys),
		.pressedKeys(pressedKeys)
	);

	toneGenerator generator (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.pressedKeys(pressedKeys),
		.sampleValid(sampleValid),
		.sample(sample),
		.sampleCredit(sampleCredit)
	);

	sampleFifo fifo (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.sampleValid(sampleValid),
		.sample(sample),
		.sampleCredit(sampleCredit),
		.dacValid(dacValid),
		.dacSample(dacSample),
		.dacCredit(dacCredit)
	);

	dacSpiSerializer serializer (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.dacValid(dacValid),
		.dacSample(dacSample),
		.dacCredit(dacCredit),
		.spiSclk(spiSclk),
		.spiSyncN(spiSyncN),
		.spiDin(spiDin)
	);

endmodule

//--- musicBoxPkg.sv
/*
	Music box shared definitions
	Widths, tone table, counter types and timing constants for the live-play path
*/
package musicBoxPkg;

	// ------------------------------------------------------------------
	// Keys and tones
	// ------------------------------------------------------------------
	localparam int NUM_KEYS        = 6;
	localparam int DEBOUNCE_CYCLES = 16;   // Raw mask must hold this long
	localparam int SAMPLE_PERIOD   = 40;   // Clocks between sample ticks
	localparam int KEY_HALF_PERIOD [NUM_KEYS] = '{2, 3, 4, 5, 6, 8};  // In samples
	localparam int KEY_AMPLITUDE   = 40;   // Per key in its high phase
	localparam int LEVEL_MAX       = 255;
	localparam int DAC_SCALE       = 16;   // 256 * 16 fills the 12 bit DAC

	// Buffering and DAC framing
	localparam int FIFO_DEPTH = 4;         // Also the producer's starting credits
	localparam int SCLK_HALF  = 2;
	localparam int FRAME_BITS = 16;        // 4 control bits then 12 data bits
	localparam int GAP_CYCLES = 2;         // SYNC high between frames

	// ------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------
	typedef logic [NUM_KEYS-1:0]   keyMaskT;
	typedef logic [7:0]            levelT;
	typedef logic [8:0]            levelSumT;   // One bit over levelT so the clip shows
	typedef logic [11:0]           dacSampleT;
	typedef logic [FRAME_BITS-1:0] frameT;

	// Counters
	typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0] debounceCountT;
	typedef logic [$clog2(SAMPLE_PERIOD)-1:0]   tickCountT;
	typedef logic [3:0]                         phaseCountT;  // Half periods up to 16
	typedef logic [$clog2(FIFO_DEPTH + 1)-1:0]  fifoCountT;   // Entries or credits
	typedef logic [$clog2(FIFO_DEPTH)-1:0]      fifoPtrT;
	typedef logic [$clog2(SCLK_HALF + 1)-1:0]   sclkCountT;
	typedef logic [$clog2(GAP_CYCLES + 1)-1:0]  gapCountT;
	typedef logic [$clog2(FRAME_BITS)-1:0]      bitCountT;

	typedef enum logic [1:0] {SerIdle, SerShift, SerGap} serializerStateT;

endpackage

//--- musicBox_properties.sv
/*
	Music box bound assertions
	FIFO occupancy checks or SPI framing checks, chosen per bind target
*/
module musicBox_properties #(
	parameter bit checkFifo = 1'b1
) (
	input logic                   clock_50Mhz,
	input logic                   reset,
	input musicBoxPkg::fifoCountT count,
	input logic                   sampleValid,
	input logic                   pop,
	input logic                   spiSyncN,
	input logic                   spiSclk
);
	import musicBoxPkg::*;

	if (checkFifo) begin : fifoChecks
		countLimit: assert property (@(posedge clock_50Mhz) disable iff (reset)
			count <= fifoCountT'(FIFO_DEPTH))
			else $error("FIFO count above depth");
		noPushFull: assert property (@(posedge clock_50Mhz) disable iff (reset)
			sampleValid |-> (count < fifoCountT'(FIFO_DEPTH)))
			else $error("Push into a full FIFO");
	end else begin : spiChecks
		logic [7:0] lowCount;   // Cycles SYNC has been low

		always_ff @(posedge clock_50Mhz) begin
			if (reset || spiSyncN)
				lowCount <= '0;
			else
				lowCount <= lowCount + 1'b1;
		end

		syncLength: assert property (@(posedge clock_50Mhz) disable iff (reset)
			$rose(spiSyncN) |-> (lowCount == 8'(FRAME_BITS * 2 * SCLK_HALF)))
			else $error("SYNC low for the wrong number of cycles");
		sclkIdle: assert property (@(posedge clock_50Mhz) disable iff (reset)
			spiSyncN |-> !spiSclk)
			else $error("SCLK high outside a frame");
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the music box testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_musicBox -o tbSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tbSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "No pass line in the log"
	exit 1
fi
exit 0

//--- sampleFifo.sv
/*
	Sample FIFO
	Four-entry buffer between tone generator and DAC serializer, returning a
	producer credit per pop and popping only on a consumer credit
*/
module sampleFifo (
	input  logic                   clock_50Mhz,
	input  logic                   reset,
	input  logic                   sampleValid,
	input  musicBoxPkg::dacSampleT sample,
	output logic                   sampleCredit,
	output logic                   dacValid,
	output musicBoxPkg::dacSampleT dacSample,
	input  logic                   dacCredit
);
	import musicBoxPkg::*;

	dacSampleT fifoMem [FIFO_DEPTH];
	fifoPtrT   wrPtr;
	fifoPtrT   rdPtr;
	fifoCountT count;            // Entries held
	logic      consumerCredit;   // Serializer can take one sample
	logic      pop;

	function automatic fifoPtrT nextPtr(input fifoPtrT ptr);
		return (ptr == fifoPtrT'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pop       = consumerCredit && (count != '0);
	assign dacValid  = pop;             // Head leaves in the pop cycle
	assign dacSample = fifoMem[rdPtr];

	// ------------------------------------------------------------------
	// Pointers, count and credits
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			wrPtr          <= '0;
			rdPtr          <= '0;
			count          <= '0;
			consumerCredit <= 1'b1;
			sampleCredit   <= 1'b0;
		end else begin
			if (sampleValid)
				wrPtr <= nextPtr(wrPtr);  // Producer credits keep this off a full FIFO
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({sampleValid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			consumerCredit <= (consumerCredit && !pop) || dacCredit;
			sampleCredit   <= pop;  // Slot freed
		end
	end

	always_ff @(posedge clock_50Mhz) begin
		if (sampleValid)
			fifoMem[wrPtr] <= sample;
	end

endmodule

//--- tb_musicBox.sv
/*
	Music box testbench
	Drives key masks into the live-play path, rebuilds the DAC SPI frames
	and checks them against a square-tone reference model
*/
module tb_musicBox;
	import musicBoxPkg::*;

	localparam int MAX_CARRY = 10;    // Old-mask frames still in flight after a change

	logic        clock_50Mhz;
	logic        reset;
	keyMaskT     musicKeys;          // Active low
	logic        spiSclk;
	logic        spiSyncN;
	logic        spiDin;

	logic [15:0] frameQ [$];         // Captured frames in order
	logic [15:0] shiftIn;
	int          bitsSeen;
	int          errorCount;
	int          checkCount;
	bit          timedOut;           // A frame wait ran out, later segments skipped
	keyMaskT     curMask;            // Mask whose pattern is running
	int          curIdx;             // Next sample index of that pattern
	int          nextPos;            // First frame not yet checked

	musicBox dut0 (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.musicKeys(musicKeys),
		.spiSclk(spiSclk),
		.spiSyncN(spiSyncN),
		.spiDin(spiDin)
	);

	bind sampleFifo musicBox_properties #(.checkFifo(1'b1)) fifoProps (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.count(count),
		.sampleValid(sampleValid),
		.pop(pop),
		.spiSyncN(1'b1),
		.spiSclk(1'b0)
	);

	bind dacSpiSerializer musicBox_properties #(.checkFifo(1'b0)) spiProps (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.count('0),
		.sampleValid(1'b0),
		.pop(1'b0),
		.spiSyncN(spiSyncN),
		.spiSclk(spiSclk)
	);

	initial clock_50Mhz = 1'b0;
	always #2 clock_50Mhz = ~clock_50Mhz;  // Period 4

	// ------------------------------------------------------------------
	// Reference model and check
	// ------------------------------------------------------------------
	// Expected frame for a mask at sample index idx
	function automatic logic [15:0] expectedFrame(input keyMaskT mask, input int idx);
		int level;
		level = 0;
		for (int k = 0; k < NUM_KEYS; k++) begin
			if (mask[k] && ((idx / KEY_HALF_PERIOD[k]) % 2 == 0))
				level = level + KEY_AMPLITUDE;   // High half of the square
		end
		if (level > LEVEL_MAX)
			level = LEVEL_MAX;   // Clip
		return 16'(level * DAC_SCALE);   // Control nibble stays zero
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------
	// SPI frame capture
	// ------------------------------------------------------------------
	// DAC side samples on the falling SCLK and the SYNC rise ends the frame
	always @(negedge spiSclk or posedge spiSyncN) begin
		if (spiSyncN === 1'b1) begin
			if (bitsSeen != 0) begin
				errorCount++;
				$display("Frame cut short after %0d bits at time %0t", bitsSeen, $time);
			end
			bitsSeen = 0;
		end else if (spiSyncN === 1'b0) begin
			shiftIn = {shiftIn[14:0], spiDin};  // MSB first
			bitsSeen++;
			if (bitsSeen == FRAME_BITS) begin
				frameQ.push_back(shiftIn);
				bitsSeen = 0;
			end
		end
	end

	// ------------------------------------------------------------------
	// Waits and segments
	// ------------------------------------------------------------------
	task automatic waitFrames(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (frameQ.size() < target && cycles < limit) begin
			@(posedge clock_50Mhz);
			cycles++;
		end
		if (frameQ.size() < target) begin
			errorCount++;
			timedOut = 1'b1;
			$display("Timed out waiting for SPI frames, have %0d of %0d", frameQ.size(),
				target);
		end
	endtask

	// Hold a mask for n frames and compare them
	task automatic playSegment(input keyMaskT newMask, input int n);
		int  start;
		int  split;
		bit  match;
		logic [15:0] exp;
		if (timedOut)
			return;
		@(posedge clock_50Mhz);
		#1 musicKeys = ~newMask;
		start = nextPos;
		waitFrames(start + n, n * 100 + 1000);
		if (timedOut)
			return;
		// Old pattern may still drain from the FIFO before the new one
		split = -1;
		for (int s = 0; s < n && s <= MAX_CARRY && split < 0; s++) begin
			match = 1'b1;
			for (int j = 0; j < n; j++) begin
				exp = (j < s) ? expectedFrame(curMask, curIdx + j)
				              : expectedFrame(newMask, j - s);
				if (frameQ[start + j] !== exp)
					match = 1'b0;
			end
			if (match)
				split = s;
		end
		if (split < 0) begin
			errorCount++;
			$display("No restart point found for mask %b at time %0t", newMask, $time);
			split = 0;
		end
		for (int j = 0; j < n; j++) begin
			exp = (j < split) ? expectedFrame(curMask, curIdx + j)
			                  : expectedFrame(newMask, j - split);
			checkValue("spiFrame", frameQ[start + j], exp);
		end
		curMask = newMask;
		curIdx  = n - split;
		nextPos = start + n;
	endtask

	// New nonzero mask unlike the current one
	function automatic keyMaskT pickMask();
		keyMaskT m;
		do
			m = keyMaskT'($urandom);
		while (m == curMask || m == '0);
		return m;
	endfunction

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		keyMaskT m;
		int      k;
		void'($urandom(35959));
		errorCount = 0;
		checkCount = 0;
		timedOut   = 1'b0;
		bitsSeen   = 0;
		shiftIn    = '0;
		curMask    = '0;
		curIdx     = 0;
		nextPos    = 0;
		musicKeys  = '1;   // All released
		reset      = 1'b1;
		repeat (10) @(posedge clock_50Mhz);
		#1 reset = 1'b0;

		@(posedge clock_50Mhz);
		#1;
		checkValue("spiSyncN", 16'(spiSyncN), 16'h1);
		checkValue("spiSclk", 16'(spiSclk), 16'h0);

		playSegment('0, 6);                              // Silence
		k = $urandom_range(0, NUM_KEYS - 1);
		playSegment(keyMaskT'(1 << k), $urandom_range(12, 16));  // One key
		m = pickMask();
		playSegment(m, $urandom_range(12, 16));          // Mixed keys
		playSegment('1, $urandom_range(12, 16));         // All six
		m = pickMask();
		playSegment(m, 40);                              // Long run under back-pressure
		playSegment('0, 8);

		$display("Checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- toneGenerator.sv
/*
	Tone generator
	Sums one square tone per held key on each sample tick and sends the
	scaled DAC code to the sample FIFO while it holds credits
*/
module toneGenerator (
	input  logic                   clock_50Mhz,
	input  logic                   reset,
	input  musicBoxPkg::keyMaskT   pressedKeys,
	output logic                   sampleValid,
	output musicBoxPkg::dacSampleT sample,
	input  logic                   sampleCredit   // One pulse per FIFO pop
);
	import musicBoxPkg::*;

	tickCountT           tickCount;
	logic                tickPending;   // Tick seen but no credit yet
	fifoCountT           creditCount;
	keyMaskT             lastKeys;
	phaseCountT          phaseCount [NUM_KEYS];
	logic [NUM_KEYS-1:0] phaseHigh;

	logic                tick;
	logic                send;
	logic                keysChanged;
	phaseCountT          nextCount [NUM_KEYS];
	logic [NUM_KEYS-1:0] nextHigh;
	levelSumT            levelSum;
	levelT               clippedLevel;

	assign tick        = tickCount == tickCountT'(SAMPLE_PERIOD - 1);
	assign send        = (tick || tickPending) && (creditCount != '0);
	assign keysChanged = pressedKeys != lastKeys;

	// ------------------------------------------------------------------
	// Sample tick and credit count
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			tickCount   <= '0;
			tickPending <= 1'b0;
			creditCount <= fifoCountT'(FIFO_DEPTH);  // FIFO starts empty
		end else begin
			tickCount   <= tick ? '0 : tickCount + 1'b1;
			tickPending <= (tick || tickPending) && !send;
			case ({send, sampleCredit})
				2'b10:   creditCount <= creditCount - 1'b1;
				2'b01:   creditCount <= creditCount + 1'b1;
				default: creditCount <= creditCount;  // Both or neither
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Per key phase and level sum
	// ------------------------------------------------------------------
	always_comb begin
		levelSum = '0;
		for (int k = 0; k < NUM_KEYS; k++) begin
			// New mask restarts every key at index 0, a high phase
			nextCount[k] = keysChanged ? '0 : phaseCount[k];
			nextHigh[k]  = keysChanged || phaseHigh[k];
			if (pressedKeys[k] && nextHigh[k])
				levelSum = levelSum + levelSumT'(KEY_AMPLITUDE);
			if (send) begin  // Index moves only when a sample goes out
				if (nextCount[k] == phaseCountT'(KEY_HALF_PERIOD[k] - 1)) begin
					nextCount[k] = '0;
					nextHigh[k]  = !nextHigh[k];
				end else begin
					nextCount[k] = nextCount[k] + 1'b1;
				end
			end
		end
	end

	assign clippedLevel = (levelSum > LEVEL_MAX) ? levelT'(LEVEL_MAX) : levelT'(levelSum);

	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			lastKeys    <= '0;
			sampleValid <= 1'b0;
			phaseCount  <= '{default: '0};
			phaseHigh   <= '1;
		end else begin
			lastKeys    <= pressedKeys;
			sampleValid <= send;
			phaseCount  <= nextCount;
			phaseHigh   <= nextHigh;
		end
	end

	always_ff @(posedge clock_50Mhz) begin
		if (send)
			sample <= dacSampleT'(clippedLevel * DAC_SCALE);  // Level to DAC code
	end

endmodule
